/* build.f */
+incdir+design
design/load_cache_pkg.sv
design/store_forward.sv
design/refill_buffer.sv
design/way_lfsr.sv
design/load_fsm.sv
design/load_cache_ctrl.sv
testbench/tb_load_cache_ctrl.sv

/* design/load_cache_ctrl.sv */
// ----------------------------------------
// Load-side data cache controller, top level
// Connects forwarding, the refill buffer, the way
// select and the controller FSM
// ----------------------------------------

`timescale 1ns/1ps

`include "load_cache_settings.svh"

module load_cache_ctrl import load_cache_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    // Load unit
    input  logic                       ldu_read_cache_i,
    input  full_address_t              ldu_address_i,
    output word_t                      ldu_data_o,
    output logic                       data_valid_o,
    output logic                       idle_o,

    // Store unit
    input  full_address_t              stu_address_i,
    input  word_t                      stu_data_i,
    input  logic                       stu_idle_i,

    // Store buffer
    input  logic                       str_buf_address_match_i,
    input  word_t                      str_buf_data_i,

    // Cache arrays
    output logic                       cache_read_o,
    output logic                       cache_write_o,
    output logic                       cache_tag_write_o,
    output cache_address_t             cache_addr_o,
    output word_t                      cache_wdata_o,
    input  word_t                      cache_data_i,
    input  logic                       port1_hit_i,
    output logic                       port0_request_o,
    input  logic                       port0_granted_i,
    output ways_t                      random_way_o,

    // External memory
    output logic                       cpu_load_req_o,
    input  word_t                      ext_data_i,
    input  logic                       ext_data_valid_i,
    input  logic [`LC_BLOCK_WORDS-1:0] word_number_i
);

    logic      fwd_hit;
    word_t     fwd_data;
    logic      word_avail;
    word_t     next_word;
    word_sel_t next_sel;
    logic      line_done;
    logic      pop;
    logic      clear;
    logic      hold_way;

    store_forward u_store_forward (
        .ldu_address_i           (ldu_address_i),
        .stu_address_i           (stu_address_i),
        .stu_data_i              (stu_data_i),
        .stu_idle_i              (stu_idle_i),
        .str_buf_address_match_i (str_buf_address_match_i),
        .str_buf_data_i          (str_buf_data_i),
        .fwd_hit_o               (fwd_hit),
        .fwd_data_o              (fwd_data)
    );

    refill_buffer u_refill_buffer (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .ext_data_i       (ext_data_i),
        .ext_data_valid_i (ext_data_valid_i),
        .word_number_i    (word_number_i),
        .pop_i            (pop),
        .clear_i          (clear),
        .word_avail_o     (word_avail),
        .next_word_o      (next_word),
        .next_sel_o       (next_sel),
        .line_done_o      (line_done)
    );

    way_lfsr u_way_lfsr (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .hold_i       (hold_way),
        .random_way_o (random_way_o)
    );

    load_fsm u_load_fsm (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .ldu_read_cache_i  (ldu_read_cache_i),
        .ldu_address_i     (ldu_address_i),
        .fwd_hit_i         (fwd_hit),
        .fwd_data_i        (fwd_data),
        .port1_hit_i       (port1_hit_i),
        .cache_data_i      (cache_data_i),
        .word_avail_i      (word_avail),
        .next_word_i       (next_word),
        .next_sel_i        (next_sel),
        .line_done_i       (line_done),
        .port0_granted_i   (port0_granted_i),
        .pop_o             (pop),
        .clear_o           (clear),
        .hold_way_o        (hold_way),
        .cache_read_o      (cache_read_o),
        .cache_write_o     (cache_write_o),
        .cache_tag_write_o (cache_tag_write_o),
        .cache_addr_o      (cache_addr_o),
        .cache_wdata_o     (cache_wdata_o),
        .cpu_load_req_o    (cpu_load_req_o),
        .port0_request_o   (port0_request_o),
        .ldu_data_o        (ldu_data_o),
        .data_valid_o      (data_valid_o),
        .idle_o            (idle_o)
    );

endmodule

/* design/load_cache_pkg.sv */
// ----------------------------------------
// Shared types for the load cache controller
// Import with a wildcard in the module header
// ----------------------------------------

`include "load_cache_settings.svh"

package load_cache_pkg;

    // One data word
    typedef logic [`LC_WORD_W-1:0] word_t;

    // Position of a word inside a cache line
    typedef logic [$clog2(`LC_BLOCK_WORDS)-1:0] word_sel_t;

    // Load address as issued by the load unit
    // The byte offset is not used for word accesses
    typedef struct packed {
        logic [`LC_TAG_W-1:0]   tag;
        logic [`LC_INDEX_W-1:0] index;
        word_sel_t              word_sel;
        logic [1:0]             byte_off;
    } full_address_t;

    // Address presented to the cache arrays, byte offset dropped
    typedef struct packed {
        logic [`LC_TAG_W-1:0]   tag;
        logic [`LC_INDEX_W-1:0] index;
        word_sel_t              word_sel;
    } cache_address_t;

    // One-hot way vector
    typedef logic [`LC_WAYS-1:0] ways_t;

endpackage

/* design/load_cache_settings.svh */
// ----------------------------------------
// Sizing macros for the load-side data cache controller
// Include this header wherever a width is needed
// The shared types built on these live in load_cache_pkg
// ----------------------------------------

`ifndef LOAD_CACHE_SETTINGS_SVH
`define LOAD_CACHE_SETTINGS_SVH

// Width of one data word moved between memory, cache and load unit
`define LC_WORD_W 32

// Number of words in a cache line, memory returns them one per transfer
`define LC_BLOCK_WORDS 4

// Associativity of the data cache
`define LC_WAYS 4

// Tag bits kept per line
`define LC_TAG_W 20

// Bits that select the set inside a way
`define LC_INDEX_W 8

`endif

/* design/load_fsm.sv */
// ----------------------------------------
// Load controller state machine
// Sequences forwarding, cache lookup, the miss request and
// the refill of the line into the cache
// Requests are taken whenever idle_o is high
// ----------------------------------------

`timescale 1ns/1ps

module load_fsm import load_cache_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_n_i,

    // Load unit request
    input  logic           ldu_read_cache_i,
    input  full_address_t  ldu_address_i,

    // Forwarding result
    input  logic           fwd_hit_i,
    input  word_t          fwd_data_i,

    // Cache read port response
    input  logic           port1_hit_i,
    input  word_t          cache_data_i,

    // Refill buffer status
    input  logic           word_avail_i,
    input  word_t          next_word_i,
    input  word_sel_t      next_sel_i,
    input  logic           line_done_i,

    // Cache write port arbitration
    input  logic           port0_granted_i,

    // Refill buffer and way select control
    output logic           pop_o,
    output logic           clear_o,
    output logic           hold_way_o,

    // Cache control
    output logic           cache_read_o,
    output logic           cache_write_o,
    output logic           cache_tag_write_o,
    output cache_address_t cache_addr_o,
    output word_t          cache_wdata_o,

    // Memory and port requests
    output logic           cpu_load_req_o,
    output logic           port0_request_o,

    // Load unit response
    output word_t          ldu_data_o,
    output logic           data_valid_o,
    output logic           idle_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_CACHE,
        COMPARE_TAG,
        DATA_STABLE,
        MEMORY_REQUEST,
        ALLOCATE
    } state_t;

    state_t state_q, state_d;
    word_t  result_q, result_d;
    logic   accept;

    // ----------------------------------------
    // State and result registers
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Holds the forwarded or hit word for DATA_STABLE
    always_ff @(posedge clk_i) begin
        result_q <= result_d;
    end

    // ----------------------------------------
    // Next state and outputs
    // ----------------------------------------

    always_comb begin
        state_d           = state_q;
        result_d          = result_q;
        accept            = 1'b0;
        pop_o             = 1'b0;
        clear_o           = 1'b0;
        hold_way_o        = 1'b0;
        cache_read_o      = 1'b0;
        cache_write_o     = 1'b0;
        cache_tag_write_o = 1'b0;
        cpu_load_req_o    = 1'b0;
        port0_request_o   = 1'b0;
        data_valid_o      = 1'b0;

        // By default the cache sees the word the load asks for
        cache_addr_o.tag      = ldu_address_i.tag;
        cache_addr_o.index    = ldu_address_i.index;
        cache_addr_o.word_sel = ldu_address_i.word_sel;

        case (state_q)
            IDLE: begin
                accept = 1'b1;
            end

            // Tag and data come back two cycles after the read
            WAIT_CACHE: begin
                state_d = COMPARE_TAG;
            end

            COMPARE_TAG: begin
                if (port1_hit_i) begin
                    result_d = cache_data_i;
                    state_d  = DATA_STABLE;
                end else begin
                    state_d = MEMORY_REQUEST;
                end
            end

            DATA_STABLE: begin
                data_valid_o = 1'b1;
                state_d      = IDLE;
            end

            // One-cycle request for the whole line, victim way now frozen
            MEMORY_REQUEST: begin
                cpu_load_req_o = 1'b1;
                hold_way_o     = 1'b1;
                state_d        = ALLOCATE;
            end

            ALLOCATE: begin
                hold_way_o = 1'b1;

                if (line_done_i) begin
                    // Whole line written, release the buffer and take new loads
                    clear_o = 1'b1;
                    accept  = 1'b1;
                    state_d = IDLE;
                end else begin
                    port0_request_o       = 1'b1;
                    cache_addr_o.word_sel = next_sel_i;

                    // Write one buffered word per granted cycle
                    if (port0_granted_i && word_avail_i) begin
                        pop_o         = 1'b1;
                        cache_write_o = 1'b1;

                        // Word 0 also sets the tag, valid and clean
                        cache_tag_write_o = next_sel_i == '0;

                        // The requested word is usable as soon as it lands
                        data_valid_o = next_sel_i == ldu_address_i.word_sel;
                    end
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // Request acceptance, shared by IDLE and the end of a refill
        idle_o = accept;
        if (accept && ldu_read_cache_i) begin
            if (fwd_hit_i) begin
                // Forwarded word skips the cache entirely
                result_d = fwd_data_i;
                state_d  = DATA_STABLE;
            end else begin
                cache_read_o = 1'b1;
                state_d      = WAIT_CACHE;
            end
        end
    end

    // Refill data goes straight from the buffer to the cache
    assign cache_wdata_o = next_word_i;

    // During a refill the load sees the word being written
    assign ldu_data_o = (state_q == ALLOCATE) ? next_word_i : result_q;

endmodule

/* design/refill_buffer.sv */
// ----------------------------------------
// Line buffer for a cache refill
// Memory delivers the line one word at a time, each word is
// parked in its slot and handed out in order on pop_i
// A word can be popped the cycle after it arrives
// ----------------------------------------

`timescale 1ns/1ps

`include "load_cache_settings.svh"

module refill_buffer import load_cache_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    // Memory side, word_number_i is one-hot
    input  word_t                      ext_data_i,
    input  logic                       ext_data_valid_i,
    input  logic [`LC_BLOCK_WORDS-1:0] word_number_i,

    // Controller side
    input  logic                       pop_i,
    input  logic                       clear_i,
    output logic                       word_avail_o,
    output word_t                      next_word_o,
    output word_sel_t                  next_sel_o,
    output logic                       line_done_o
);

    // One extra bit so a full line can be counted
    localparam int CNT_W = $clog2(`LC_BLOCK_WORDS) + 1;

    word_t            line_q [`LC_BLOCK_WORDS];
    logic [CNT_W-1:0] wr_cnt_q;
    logic [CNT_W-1:0] rd_cnt_q;

    // ----------------------------------------
    // Word storage
    // ----------------------------------------

    // Each slot loads when its position bit is set
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `LC_BLOCK_WORDS; i++) begin
            if (ext_data_valid_i && word_number_i[i]) begin
                line_q[i] <= ext_data_i;
            end
        end
    end

    // ----------------------------------------
    // Arrival and allocation counters
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            wr_cnt_q <= '0;
            rd_cnt_q <= '0;
        end else begin
            if (ext_data_valid_i) begin
                wr_cnt_q <= wr_cnt_q + 1'b1;
            end
            if (pop_i) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
        end
    end

    // Words come in order, so the read count is also the next slot
    assign next_sel_o   = rd_cnt_q[CNT_W-2:0];
    assign next_word_o  = line_q[next_sel_o];
    assign word_avail_o = wr_cnt_q > rd_cnt_q;
    assign line_done_o  = rd_cnt_q == CNT_W'(`LC_BLOCK_WORDS);

endmodule

/* design/store_forward.sv */
// ----------------------------------------
// Store-to-load forwarding check
// Compares the load address with the store unit and
// the store buffer and picks the word to forward
// Purely combinational
// ----------------------------------------

`timescale 1ns/1ps

module store_forward import load_cache_pkg::*; (
    // Address of the pending load
    input  full_address_t ldu_address_i,

    // Store currently executing in the store unit
    input  full_address_t stu_address_i,
    input  word_t         stu_data_i,
    input  logic          stu_idle_i,

    // Store buffer lookup result
    input  logic          str_buf_address_match_i,
    input  word_t         str_buf_data_i,

    // Forwarding result
    output logic          fwd_hit_o,
    output word_t         fwd_data_o
);

    logic stu_match;

    // The store unit only holds a valid address while it is busy
    assign stu_match = !stu_idle_i && (stu_address_i == ldu_address_i);

    assign fwd_hit_o = stu_match | str_buf_address_match_i;

    // The store unit holds the youngest store, so it wins over the buffer
    assign fwd_data_o = stu_match ? stu_data_i : str_buf_data_i;

endmodule

/* design/way_lfsr.sv */
// ----------------------------------------
// Pseudo-random way select for replacement
// A 3-bit LFSR runs freely and is frozen by hold_i
// while a refill uses the chosen way
// ----------------------------------------

`timescale 1ns/1ps

`include "load_cache_settings.svh"

module way_lfsr import load_cache_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  hold_i,
    output ways_t random_way_o
);

    localparam int SEL_W = $clog2(`LC_WAYS);

    logic [2:0] lfsr_q;
    logic       feedback;

    // XNOR feedback keeps the all-ones lockup state out of the loop
    assign feedback = !(lfsr_q[2] ^ lfsr_q[1]);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lfsr_q <= 3'b010;
        end else if (!hold_i) begin
            lfsr_q <= {lfsr_q[1:0], feedback};
        end
    end

    // Turn the low bits into a one-hot way vector
    always_comb begin
        for (int i = 0; i < `LC_WAYS; i++) begin
            random_way_o[i] = lfsr_q[SEL_W-1:0] == SEL_W'(i);
        end
    end

endmodule

/* testbench/tb_load_cache_ctrl.sv */
// ----------------------------------------
// Random-stimulus testbench for the load cache controller
// Acts as cache arrays, external memory, store unit and store
// buffer, and checks every load against its own models
// Runs 200 loads from a fixed seed
// ----------------------------------------

`timescale 1ns/1ps

`include "load_cache_settings.svh"

module tb_load_cache_ctrl import load_cache_pkg::*; ();

    localparam int NUM_LOADS       = 200;
    localparam int CYCLES_PER_LOAD = 40;
    localparam int TIMEOUT_CYCLES  = NUM_LOADS * CYCLES_PER_LOAD;
    localparam int LINE_WORDS      = `LC_BLOCK_WORDS;
    localparam int SEED            = 32'h7ba48b27;

    logic                       clk_i;
    logic                       rst_n_i;
    logic                       ldu_read_cache_i;
    full_address_t              ldu_address_i;
    word_t                      ldu_data_o;
    logic                       data_valid_o;
    logic                       idle_o;
    full_address_t              stu_address_i;
    word_t                      stu_data_i;
    logic                       stu_idle_i;
    logic                       str_buf_address_match_i;
    word_t                      str_buf_data_i;
    logic                       cache_read_o;
    logic                       cache_write_o;
    logic                       cache_tag_write_o;
    cache_address_t             cache_addr_o;
    word_t                      cache_wdata_o;
    word_t                      cache_data_i;
    logic                       port1_hit_i;
    logic                       port0_request_o;
    logic                       port0_granted_i;
    ways_t                      random_way_o;
    logic                       cpu_load_req_o;
    word_t                      ext_data_i;
    logic                       ext_data_valid_i;
    logic [`LC_BLOCK_WORDS-1:0] word_number_i;

    // Cache contents by word address, and which lines hold a valid tag
    word_t      cache_model [bit [29:0]];
    bit         line_valid [bit [27:0]];

    // Reference copy of the replacement LFSR
    logic [2:0] lfsr_m;

    // What the current cycle expects from the DUT, cleared every cycle
    logic       hold_exp;
    logic       dv_exp;
    logic       wr_exp;
    logic       tag_exp;
    logic       rd_exp;
    logic       req_exp;
    logic       pr_exp;
    word_t      data_exp;

    int         cycle_cnt;
    int         errors;
    int         n_fwd;
    int         n_hit;
    int         n_miss;

    load_cache_ctrl dut0 (
        .clk_i                   (clk_i),
        .rst_n_i                 (rst_n_i),
        .ldu_read_cache_i        (ldu_read_cache_i),
        .ldu_address_i           (ldu_address_i),
        .ldu_data_o              (ldu_data_o),
        .data_valid_o            (data_valid_o),
        .idle_o                  (idle_o),
        .stu_address_i           (stu_address_i),
        .stu_data_i              (stu_data_i),
        .stu_idle_i              (stu_idle_i),
        .str_buf_address_match_i (str_buf_address_match_i),
        .str_buf_data_i          (str_buf_data_i),
        .cache_read_o            (cache_read_o),
        .cache_write_o           (cache_write_o),
        .cache_tag_write_o       (cache_tag_write_o),
        .cache_addr_o            (cache_addr_o),
        .cache_wdata_o           (cache_wdata_o),
        .cache_data_i            (cache_data_i),
        .port1_hit_i             (port1_hit_i),
        .port0_request_o         (port0_request_o),
        .port0_granted_i         (port0_granted_i),
        .random_way_o            (random_way_o),
        .cpu_load_req_o          (cpu_load_req_o),
        .ext_data_i              (ext_data_i),
        .ext_data_valid_i        (ext_data_valid_i),
        .word_number_i           (word_number_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Models and helpers
    // ----------------------------------------

    // Memory contents, a rotated word address under a fixed mask
    function automatic word_t mem_word(input logic [29:0] waddr);
        return {waddr[13:0], waddr[29:12]} ^ 32'hc3a5_0f96;
    endfunction

    task automatic stop_run(input string line);
        errors++;
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped on the first failure");
    endtask

    task automatic report_error(input string msg);
        stop_run($sformatf("ERR @%0t: %s", $time, msg));
    endtask

    // Waits for the next rising edge and drives the quiet input values 1 ns later
    task automatic start_cycle();
        @(posedge clk_i);
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout: the run did not finish within %0d cycles",
                TIMEOUT_CYCLES));
        end

        // The LFSR moves on every edge where the last cycle did not hold it
        if (!rst_n_i) begin
            lfsr_m = 3'b010;
        end else if (!hold_exp) begin
            lfsr_m = {lfsr_m[1:0], ~(lfsr_m[2] ^ lfsr_m[1])};
        end

        hold_exp = 1'b0;
        dv_exp   = 1'b0;
        wr_exp   = 1'b0;
        tag_exp  = 1'b0;
        rd_exp   = 1'b0;
        req_exp  = 1'b0;
        pr_exp   = 1'b0;

        #1;
        // Lookup and grant lines carry noise unless a cycle needs them
        port1_hit_i      = 1'($urandom);
        cache_data_i     = $urandom;
        port0_granted_i  = 1'($urandom);
        ext_data_valid_i = 1'b0;
        word_number_i    = '0;
        ext_data_i       = $urandom;
    endtask

    // Samples mid-cycle, after the inputs have settled, and runs the common checks
    task automatic sample();
        ways_t way_exp;

        #1;
        way_exp = ways_t'(1) << lfsr_m[1:0];
        assert ((random_way_o != '0) && ((random_way_o & (random_way_o - 1'b1)) == '0))
            else report_error($sformatf("random_way_o %b is not one-hot", random_way_o));
        assert (random_way_o == way_exp)
            else report_error($sformatf("random_way_o is %b, expected %b",
                random_way_o, way_exp));
        assert (data_valid_o == dv_exp)
            else report_error($sformatf("data_valid_o is %0b, expected %0b",
                data_valid_o, dv_exp));
        if (dv_exp) begin
            assert (ldu_data_o == data_exp)
                else report_error($sformatf("ldu_data_o is %h, expected %h",
                    ldu_data_o, data_exp));
        end
        assert (cache_write_o == wr_exp)
            else report_error($sformatf("cache_write_o is %0b, expected %0b",
                cache_write_o, wr_exp));
        assert (cache_tag_write_o == (wr_exp && tag_exp))
            else report_error($sformatf("cache_tag_write_o is %0b, expected %0b",
                cache_tag_write_o, wr_exp && tag_exp));
        assert (cache_read_o == rd_exp)
            else report_error($sformatf("cache_read_o is %0b, expected %0b",
                cache_read_o, rd_exp));
        assert (cpu_load_req_o == req_exp)
            else report_error($sformatf("cpu_load_req_o is %0b, expected %0b",
                cpu_load_req_o, req_exp));
        assert (port0_request_o == pr_exp)
            else report_error($sformatf("port0_request_o is %0b, expected %0b",
                port0_request_o, pr_exp));
    endtask

    // The cycle after the last refill write, used when no request comes in it
    task automatic check_refill_end();
        sample();
        assert (idle_o) else report_error("idle_o did not return after the refill");
    endtask

    // ----------------------------------------
    // One load from request to completion
    // ----------------------------------------

    // With started set, the request goes into the cycle where a refill ends
    task automatic run_load(input bit started, output bit open_cycle);
        full_address_t addr;
        logic [27:0]   line_key;
        int            kind;
        logic          stu_hit;
        logic          buf_hit;
        logic          hit;
        word_t         fwd_word;
        ways_t         frozen_way;
        int            arrived;
        int            written;
        int            dv_count;
        logic          give;

        open_cycle = 1'b0;

        // A small pool of tags and sets so lines get reused and hit
        addr.tag      = 20'h3a5c0 | 20'($urandom % 4);
        addr.index    = 8'h5a ^ 8'($urandom % 8);
        addr.word_sel = 2'($urandom);
        addr.byte_off = 2'($urandom);
        line_key      = {addr.tag, addr.index};

        // Kind 0 is a store unit match, 1 a store buffer match alone,
        // 2 an idle store unit that still shows the load address
        kind    = $urandom % 8;
        stu_hit = kind == 0;
        buf_hit = (kind == 1) || (stu_hit && ($urandom % 2 == 1));

        if (!started) begin
            start_cycle();
        end
        ldu_read_cache_i        = 1'b1;
        ldu_address_i           = addr;
        stu_data_i              = $urandom;
        str_buf_data_i          = $urandom;
        str_buf_address_match_i = buf_hit;
        if (stu_hit || kind == 2) begin
            stu_address_i = addr;
            stu_idle_i    = !stu_hit;
        end else begin
            // Differs from the load in exactly one address bit
            stu_address_i = full_address_t'(addr ^ (32'h1 << ($urandom % 32)));
            stu_idle_i    = 1'($urandom);
        end
        fwd_word = stu_hit ? stu_data_i : str_buf_data_i;
        rd_exp   = !(stu_hit || buf_hit);
        sample();
        assert (idle_o) else report_error("idle_o low in the request cycle");
        if (rd_exp) begin
            assert (cache_addr_o == {line_key, addr.word_sel})
                else report_error($sformatf("cache_addr_o is %h on the lookup",
                    cache_addr_o));
        end

        // Forwarded word comes back the next cycle
        if (stu_hit || buf_hit) begin
            start_cycle();
            ldu_read_cache_i = 1'b0;
            dv_exp           = 1'b1;
            data_exp         = fwd_word;
            sample();
            n_fwd++;
            return;
        end

        start_cycle();
        ldu_read_cache_i = 1'b0;
        sample();

        // Tag compare result answers the read from two cycles back
        start_cycle();
        hit          = line_valid.exists(line_key);
        port1_hit_i  = hit;
        cache_data_i = hit ? cache_model[{line_key, addr.word_sel}] : word_t'($urandom);
        sample();

        start_cycle();
        if (hit) begin
            dv_exp   = 1'b1;
            data_exp = cache_model[{line_key, addr.word_sel}];
            sample();
            n_hit++;
            return;
        end

        // Miss, the line request goes out and the victim way freezes
        req_exp  = 1'b1;
        hold_exp = 1'b1;
        sample();
        frozen_way = ways_t'(1) << lfsr_m[1:0];
        n_miss++;

        arrived  = 0;
        written  = 0;
        dv_count = 0;
        while (written < LINE_WORDS) begin
            start_cycle();
            hold_exp = 1'b1;
            pr_exp   = 1'b1;
            port0_granted_i = ($urandom % 4) != 0;

            // Memory sends the line in order with random gaps
            give = (arrived < LINE_WORDS) && ($urandom % 3 != 0);
            ext_data_valid_i = give;
            ext_data_i       = mem_word({line_key, 2'(arrived)});
            if (give) begin
                word_number_i[arrived] = 1'b1;
            end

            // A word can be written the cycle after it arrives
            wr_exp   = port0_granted_i && (written < arrived);
            tag_exp  = written == 0;
            dv_exp   = wr_exp && (written == int'(addr.word_sel));
            data_exp = mem_word({line_key, 2'(written)});
            sample();
            assert (random_way_o == frozen_way)
                else report_error("random_way_o changed during the refill");
            assert (!idle_o) else report_error("idle_o high during the refill");
            if (wr_exp) begin
                assert (cache_addr_o == {line_key, 2'(written)})
                    else report_error($sformatf("cache_addr_o is %h on refill write %0d",
                        cache_addr_o, written));
                assert (cache_wdata_o == data_exp)
                    else report_error($sformatf("cache_wdata_o is %h, expected %h",
                        cache_wdata_o, data_exp));
                cache_model[{line_key, 2'(written)}] = data_exp;
                if (written == 0) begin
                    line_valid[line_key] = 1'b1;
                end
                written++;
            end
            if (data_valid_o) begin
                dv_count++;
            end
            if (give) begin
                arrived++;
            end
        end
        assert (dv_count == 1)
            else report_error($sformatf("data_valid_o seen %0d times on a miss", dv_count));

        // Last word written, the controller takes requests again in this cycle
        start_cycle();
        hold_exp   = 1'b1;
        open_cycle = 1'b1;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        int gap;
        bit refill_open;

        void'($urandom(SEED));
        rst_n_i                 = 1'b0;
        ldu_read_cache_i        = 1'b0;
        ldu_address_i           = '0;
        stu_address_i           = '0;
        stu_data_i              = '0;
        stu_idle_i              = 1'b1;
        str_buf_address_match_i = 1'b0;
        str_buf_data_i          = '0;
        cache_data_i            = '0;
        port1_hit_i             = 1'b0;
        port0_granted_i         = 1'b0;
        ext_data_i              = '0;
        ext_data_valid_i        = 1'b0;
        word_number_i           = '0;
        lfsr_m                  = 3'b010;
        hold_exp                = 1'b0;
        cycle_cnt               = 0;
        errors                  = 0;
        n_fwd                   = 0;
        n_hit                   = 0;
        n_miss                  = 0;
        refill_open             = 1'b0;

        repeat (8) start_cycle();
        rst_n_i = 1'b1;
        sample();
        assert (idle_o) else report_error("idle_o low after reset");

        for (int i = 0; i < NUM_LOADS; i++) begin
            gap = $urandom % 3;
            // Without a gap the next request lands in the cycle a refill ends
            if (refill_open && gap != 0) begin
                check_refill_end();
                refill_open = 1'b0;
            end
            repeat (gap) begin
                start_cycle();
                sample();
                assert (idle_o) else report_error("idle_o low between loads");
            end
            run_load(refill_open, refill_open);
        end
        if (refill_open) begin
            check_refill_end();
        end

        $display("Loads: %0d forwarded, %0d hits, %0d misses", n_fwd, n_hit, n_miss);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
